//--- filelist.f
sram_fifo_pkg.sv
word_buffer_fifo.sv
sram_fifo_ctrl.sv
sram_fifo_regs.sv
sram_fifo_top.sv
tb_sram_model.sv
tb_checker.sv
tb_sram_fifo.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sram fifo testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_sram_fifo -o tb_sram_fifo_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sram_fifo_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- sram_fifo_ctrl.sv
// ----------------------------------------------------------------------
// sram ring buffer controller
// writes buffered words into the sram as two halves, prefetches words
// for the host port and serializes them into bytes
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module sram_fifo_ctrl
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH = 1048576
) (
    input  logic         BUS_CLK,
    input  logic         RST,
    input  logic [31:0]  buf_data,
    input  logic         buf_empty,
    output logic         buf_pop,
    output sram_bus_t    sram,
    input  logic [15:0]  sram_rdata,
    input  logic         usb_read,
    output logic [7:0]   usb_data,
    output logic         rd_error_inc,
    output fifo_status_t status
);

    localparam logic [1:0] RD_TRY  = 2'd0;
    localparam logic [1:0] RD_SRAM = 2'd1;
    localparam logic [1:0] RD_HOLD = 2'd2;

    localparam logic [SRAM_AW-1:0] LAST_ADDR = SRAM_AW'(DEPTH - 1);

    logic [SRAM_AW-1:0] wr_ptr;
    logic [SRAM_AW-1:0] rd_ptr;
    logic [SRAM_AW-1:0] wr_ptr_next;
    logic [SRAM_AW-1:0] rd_ptr_next;
    logic               full_ff;
    logic               upper_half;
    logic               ring_empty;
    logic               write_sram;
    logic               read_sram;
    logic [1:0]         rd_state;
    logic [1:0]         rd_state_next;
    logic               byte_sel;
    logic [15:0]        held_word;
    logic [SRAM_AW:0]   ring_words;
    logic [SRAM_AW:0]   level;

    function automatic logic [SRAM_AW-1:0] ptr_inc(input logic [SRAM_AW-1:0] p);
        return (p == LAST_ADDR) ? '0 : p + 1'b1;
    endfunction

    assign ring_empty = (wr_ptr == rd_ptr);
    assign read_sram  = (rd_state == RD_SRAM);
    assign write_sram = !buf_empty && !full_ff && !read_sram;   // reads win
    assign buf_pop    = write_sram && upper_half;

    always_comb begin
        wr_ptr_next = write_sram ? ptr_inc(wr_ptr) : wr_ptr;
        rd_ptr_next = read_sram ? ptr_inc(rd_ptr) : rd_ptr;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            full_ff    <= 1'b0;
            upper_half <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr_next;
            rd_ptr  <= rd_ptr_next;
            full_ff <= (ptr_inc(wr_ptr_next) == rd_ptr_next);  // one slot kept free
            if (write_sram)
                upper_half <= !upper_half;
        end
    end

    // read prefetch
    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            RD_TRY: begin
                if (!ring_empty)
                    rd_state_next = RD_SRAM;
            end
            RD_SRAM: begin
                rd_state_next = RD_HOLD;
            end
            RD_HOLD: begin
                if (usb_read && byte_sel)
                    rd_state_next = ring_empty ? RD_TRY : RD_SRAM;
            end
            default: begin
                rd_state_next = RD_TRY;
            end
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_state <= RD_TRY;
            byte_sel <= 1'b0;
        end else begin
            rd_state <= rd_state_next;
            if (rd_state == RD_HOLD && usb_read)
                byte_sel <= !byte_sel;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (read_sram)
            held_word <= sram_rdata;
    end

    assign usb_data     = byte_sel ? held_word[15:8] : held_word[7:0];
    assign rd_error_inc = usb_read && (rd_state != RD_HOLD) && ring_empty;

    always_comb begin
        if (wr_ptr >= rd_ptr)
            ring_words = {1'b0, wr_ptr} - {1'b0, rd_ptr};
        else
            ring_words = {1'b0, wr_ptr} + (SRAM_AW+1)'(DEPTH) - {1'b0, rd_ptr};
        level = ring_words + (SRAM_AW+1)'(rd_state == RD_HOLD);   // held word counts
    end

    assign status.size  = level;
    assign status.empty = (level == '0);
    assign status.full  = full_ff;

    assign sram.addr  = read_sram ? rd_ptr : wr_ptr;
    assign sram.wdata = upper_half ? buf_data[31:16] : buf_data[15:0];
    assign sram.we    = write_sram;
    assign sram.oe    = read_sram;

    a_no_read_empty: assert property (@(posedge BUS_CLK) disable iff (RST)
        read_sram |-> !ring_empty);

endmodule

//--- sram_fifo_pkg.sv
// ----------------------------------------------------------------------
// sram fifo shared definitions
// register map, sram address width and the structs passed between
// the buffer, the sram controller and the register file
// ----------------------------------------------------------------------
package sram_fifo_pkg;

    localparam int SRAM_AW = 20;                // 1M x 16 external sram

    localparam logic [7:0] VERSION = 8'd2;

    localparam logic [15:0] REG_CTRL  = 16'd0;  // read version, write soft reset
    localparam logic [15:0] REG_AF    = 16'd1;
    localparam logic [15:0] REG_AE    = 16'd2;
    localparam logic [15:0] REG_ERR   = 16'd3;
    localparam logic [15:0] REG_SIZE0 = 16'd4;  // read latches 5 and 6
    localparam logic [15:0] REG_SIZE1 = 16'd5;
    localparam logic [15:0] REG_SIZE2 = 16'd6;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    // polarity is active high here, pins are inverted at the top
    typedef struct packed {
        logic [SRAM_AW-1:0] addr;
        logic [15:0]        wdata;
        logic               we;
        logic               oe;
    } sram_bus_t;

    typedef struct packed {
        logic [SRAM_AW:0] size;                 // 16-bit words incl. held word
        logic             empty;
        logic             full;
    } fifo_status_t;

endpackage

//--- sram_fifo_regs.sv
// ----------------------------------------------------------------------
// sram fifo register file
// version, soft reset, thresholds, read error count, latched byte size
// and the near-full flag with hysteresis
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module sram_fifo_regs
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH            = 1048576,
    parameter int ALMOST_FULL_PCT  = 95,
    parameter int ALMOST_EMPTY_PCT = 5
) (
    input  logic         BUS_CLK,
    input  logic         RST,
    input  bus_req_t     bus,
    output logic [7:0]   bus_rdata,
    output logic         core_rst,
    input  fifo_status_t status,
    input  logic         rd_error_inc,
    output logic         near_full,
    output logic         read_error
);

    localparam logic [7:0] AF_DEFAULT = 8'(255 * ALMOST_FULL_PCT / 100);
    localparam logic [7:0] AE_DEFAULT = 8'(255 * ALMOST_EMPTY_PCT / 100);

    logic                soft_rst;
    logic [7:0]          af_val;
    logic [7:0]          ae_val;
    logic [7:0]          err_cnt;
    logic [SRAM_AW+1:0]  size_byte;
    logic [SRAM_AW+1:8]  size_hi_buf;
    logic [31:0]         level;
    logic [31:0]         set_level;
    logic [31:0]         clr_level;

    assign soft_rst = bus.wr && (bus.addr == REG_CTRL);
    assign core_rst = RST || soft_rst;

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            af_val <= AF_DEFAULT;
            ae_val <= AE_DEFAULT;
        end else if (bus.wr) begin
            if (bus.addr == REG_AF)
                af_val <= bus.wdata;
            if (bus.addr == REG_AE)
                ae_val <= bus.wdata;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst)
            err_cnt <= '0;
        else if (rd_error_inc && err_cnt != 8'hff)
            err_cnt <= err_cnt + 1'b1;                  // saturates
    end

    assign size_byte = {status.size, 1'b0};

    always_ff @(posedge BUS_CLK) begin
        if (bus.rd && bus.addr == REG_SIZE0)
            size_hi_buf <= size_byte[SRAM_AW+1:8];      // upper bytes read later
    end

    always_ff @(posedge BUS_CLK) begin
        case (bus.addr)
            REG_CTRL:  bus_rdata <= VERSION;
            REG_AF:    bus_rdata <= af_val;
            REG_AE:    bus_rdata <= ae_val;
            REG_ERR:   bus_rdata <= err_cnt;
            REG_SIZE0: bus_rdata <= size_byte[7:0];
            REG_SIZE1: bus_rdata <= size_hi_buf[15:8];
            REG_SIZE2: bus_rdata <= 8'(size_hi_buf[SRAM_AW+1:16]);
            default:   bus_rdata <= 8'h00;
        endcase
    end

    assign level     = 32'(status.size);
    assign set_level = ((32'(af_val) + 32'd1) * 32'(DEPTH)) >> 8;
    assign clr_level = ((32'(ae_val) + 32'd1) * 32'(DEPTH)) >> 8;

    always_ff @(posedge BUS_CLK) begin
        if (core_rst)
            near_full <= 1'b0;
        else if (status.empty)
            near_full <= 1'b0;
        else if (level >= set_level)
            near_full <= 1'b1;
        else if (level <= clr_level)
            near_full <= 1'b0;                          // between points holds
    end

    assign read_error = (err_cnt != 8'h00);

endmodule

//--- sram_fifo_top.sv
// ----------------------------------------------------------------------
// sram fifo top level
// word buffer, sram ring controller and register file with the
// external sram pins and the tristate data bus
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module sram_fifo_top
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH            = 1048576,
    parameter int BUF_DEPTH        = 16,
    parameter int ALMOST_FULL_PCT  = 95,
    parameter int ALMOST_EMPTY_PCT = 5
) (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  bus_req_t           bus,
    output logic [7:0]         bus_rdata,
    input  logic               in_write,
    input  logic [31:0]        in_data,
    output logic               in_ready,
    input  logic               usb_read,
    output logic [7:0]         usb_data,
    output logic [SRAM_AW-1:0] sram_addr,
    inout  wire  [15:0]        sram_io,
    output logic               sram_we_n,
    output logic               sram_oe_n,
    output logic               fifo_not_empty,
    output logic               fifo_full,
    output logic               near_full,
    output logic               read_error
);

    logic         core_rst;
    logic         buf_full;
    logic         buf_empty;
    logic         buf_pop;
    logic [31:0]  buf_data;
    logic         rd_error_inc;
    sram_bus_t    sram;
    fifo_status_t status;

    assign in_ready = !buf_full;

    word_buffer_fifo #(.WIDTH(32), .DEPTH(BUF_DEPTH)) buf0 (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .push(in_write && !buf_full),               // strobes under back-pressure dropped
        .din(in_data), .pop(buf_pop), .dout(buf_data),
        .full(buf_full), .empty(buf_empty)
    );

    sram_fifo_ctrl #(.DEPTH(DEPTH)) ctrl0 (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .buf_data(buf_data), .buf_empty(buf_empty), .buf_pop(buf_pop),
        .sram(sram), .sram_rdata(sram_io),
        .usb_read(usb_read), .usb_data(usb_data),
        .rd_error_inc(rd_error_inc), .status(status)
    );

    sram_fifo_regs #(
        .DEPTH(DEPTH), .ALMOST_FULL_PCT(ALMOST_FULL_PCT),
        .ALMOST_EMPTY_PCT(ALMOST_EMPTY_PCT)
    ) regs0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus(bus), .bus_rdata(bus_rdata),
        .core_rst(core_rst), .status(status), .rd_error_inc(rd_error_inc),
        .near_full(near_full), .read_error(read_error)
    );

    // chip and byte enables are permanently active on the board side
    assign sram_io        = sram.we ? sram.wdata : 16'hzzzz;
    assign sram_addr      = sram.addr;
    assign sram_we_n      = !sram.we;
    assign sram_oe_n      = !sram.oe;
    assign fifo_not_empty = !status.empty;
    assign fifo_full      = status.full;

endmodule

//--- tb_checker.sv
// ----------------------------------------------------------------------
// testbench checker
// byte queue model of the fifo, error counter model, value compares
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_checker
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH            = 64,
    parameter int ALMOST_FULL_PCT  = 95,
    parameter int ALMOST_EMPTY_PCT = 5
) (
    input logic        BUS_CLK,
    input logic        RST,
    input bus_req_t    bus,
    input logic        in_write,
    input logic [31:0] in_data,
    input logic        in_ready,
    input logic        usb_read,
    input logic [7:0]  usb_data,
    input logic        fifo_not_empty,
    input logic        near_full,
    input logic        read_error
);

    logic [7:0] q[$];
    int         err_model;
    int         af_model;
    int         ae_model;
    logic       nf_model;
    int         errors;
    int         checks;

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic check_eq(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int byte_count();
        return q.size();
    endfunction

    always @(posedge BUS_CLK) begin
        if (RST || (bus.wr && bus.addr == 16'd0)) begin
            q.delete();
            err_model = 0;
            af_model  = 255 * ALMOST_FULL_PCT / 100;
            ae_model  = 255 * ALMOST_EMPTY_PCT / 100;
            nf_model  = 1'b0;
        end else begin
            if (bus.wr && bus.addr == 16'd1)
                af_model = int'(bus.wdata);
            if (bus.wr && bus.addr == 16'd2)
                ae_model = int'(bus.wdata);
            if (in_write && in_ready) begin
                q.push_back(in_data[7:0]);          // low byte leaves first
                q.push_back(in_data[15:8]);
                q.push_back(in_data[23:16]);
                q.push_back(in_data[31:24]);
            end
            if (usb_read) begin
                if (!fifo_not_empty) begin
                    if (err_model < 255)
                        err_model++;
                end else if (q.size() == 0) begin
                    errors++;
                    $display("[ERROR] %0t ns: byte read while model queue empty", $time);
                end else begin
                    check_eq("usb_data", int'(usb_data), int'(q.pop_front()));
                end
            end
        end
    end

    always @(negedge BUS_CLK) begin
        if (!RST && read_error != (err_model != 0)) begin
            errors++;
            $display("[ERROR] %0t ns: read_error flag is %0b", $time, read_error);
        end
    end

    // called only while idle, so the level is the model's word count
    task automatic check_near_full();
        int lvl;
        int set_pt;
        int clr_pt;
        lvl    = q.size() / 2;
        set_pt = ((af_model + 1) * DEPTH) / 256;
        clr_pt = ((ae_model + 1) * DEPTH) / 256;
        if (lvl == 0)
            nf_model = 1'b0;
        else if (lvl >= set_pt)
            nf_model = 1'b1;
        else if (lvl <= clr_pt)
            nf_model = 1'b0;
        check_eq("near_full", int'(near_full), int'(nf_model));
    endtask

    task automatic report();
        $display("checks: %0d errors: %0d", checks, errors);
    endtask

endmodule

//--- tb_sram_fifo.sv
// ----------------------------------------------------------------------
// sram fifo testbench top
// clock and reset, dut, sram model, checker and xorshift stimulus
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clock_gen (
    output logic BUS_CLK,
    output logic RST
);
    initial begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = !BUS_CLK;
    end
    initial begin
        RST = 1'b1;
        repeat (2) @(posedge BUS_CLK);
        RST <= 1'b0;
    end
endmodule

module tb_sram_fifo
    import sram_fifo_pkg::*;
;
    localparam int DEPTH     = 64;
    localparam int BUF_DEPTH = 16;
    localparam int AF_PCT    = 75;
    localparam int AE_PCT    = 25;
    localparam logic [15:0] R_CTRL  = 16'd0;
    localparam logic [15:0] R_AF    = 16'd1;
    localparam logic [15:0] R_AE    = 16'd2;
    localparam logic [15:0] R_ERR   = 16'd3;
    localparam logic [15:0] R_SIZE0 = 16'd4;
    localparam logic [15:0] R_SIZE1 = 16'd5;
    localparam logic [15:0] R_SIZE2 = 16'd6;

    logic        BUS_CLK;
    logic        RST;
    bus_req_t    bus;
    logic [7:0]  bus_rdata;
    logic        in_write;
    logic [31:0] in_data;
    logic        in_ready;
    logic        usb_read;
    logic [7:0]  usb_data;
    logic [19:0] sram_addr;
    wire  [15:0] sram_io;
    logic        sram_we_n;
    logic        sram_oe_n;
    logic        fifo_not_empty;
    logic        fifo_full;
    logic        near_full;
    logic        read_error;
    logic [31:0] seed;
    logic [7:0]  rv;
    int          sz;

    tb_clock_gen clk0 (.BUS_CLK(BUS_CLK), .RST(RST));

    sram_fifo_top #(
        .DEPTH(DEPTH), .BUF_DEPTH(BUF_DEPTH),
        .ALMOST_FULL_PCT(AF_PCT), .ALMOST_EMPTY_PCT(AE_PCT)
    ) dut0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus(bus), .bus_rdata(bus_rdata),
        .in_write(in_write), .in_data(in_data), .in_ready(in_ready),
        .usb_read(usb_read), .usb_data(usb_data), .sram_addr(sram_addr),
        .sram_io(sram_io), .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n),
        .fifo_not_empty(fifo_not_empty), .fifo_full(fifo_full),
        .near_full(near_full), .read_error(read_error)
    );

    tb_sram_model #(.AW(20)) sram0 (
        .BUS_CLK(BUS_CLK), .addr(sram_addr), .io(sram_io),
        .we_n(sram_we_n), .oe_n(sram_oe_n)
    );

    tb_checker #(.DEPTH(DEPTH), .ALMOST_FULL_PCT(AF_PCT), .ALMOST_EMPTY_PCT(AE_PCT)) chk0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus(bus), .in_write(in_write),
        .in_data(in_data), .in_ready(in_ready), .usb_read(usb_read),
        .usb_data(usb_data), .fifo_not_empty(fifo_not_empty),
        .near_full(near_full), .read_error(read_error)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        chk0.report();
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic reg_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge BUS_CLK);
        bus <= '{addr: a, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
        @(posedge BUS_CLK);
        bus <= '{addr: 16'h0000, wdata: 8'h00, rd: 1'b0, wr: 1'b0};
        @(negedge BUS_CLK);
        d = bus_rdata;                              // registered one cycle later
    endtask

    task automatic reg_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge BUS_CLK);
        bus <= '{addr: a, wdata: d, rd: 1'b0, wr: 1'b1};
        @(posedge BUS_CLK);
        bus <= '{addr: 16'h0000, wdata: 8'h00, rd: 1'b0, wr: 1'b0};
    endtask

    task automatic write_word(input logic [31:0] d);
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while (!in_ready) begin
            @(negedge BUS_CLK);
            n++;
            if (n > 500)
                abort_run("in_ready stayed low");
        end
        @(posedge BUS_CLK);
        in_write <= 1'b1;
        in_data  <= d;
        @(posedge BUS_CLK);
        in_write <= 1'b0;
    endtask

    task automatic read_byte(input int extra_gap);
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while (!fifo_not_empty) begin
            @(negedge BUS_CLK);
            n++;
            if (n > 500)
                abort_run("fifo_not_empty stayed low");
        end
        repeat (3 + extra_gap) @(posedge BUS_CLK);
        usb_read <= 1'b1;
        @(posedge BUS_CLK);
        usb_read <= 1'b0;
        repeat (3) @(posedge BUS_CLK);
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while (chk0.byte_count() > 0) begin
            seed = xorshift32(seed);
            read_byte(int'(seed[1:0]));
            n++;
            if (n > 1000)
                abort_run("drain did not finish");
        end
        @(negedge BUS_CLK);
        chk0.check_eq("fifo_not_empty after drain", int'(fifo_not_empty), 0);
    endtask

    task automatic check_size();
        repeat (2 * BUF_DEPTH + 20) @(posedge BUS_CLK);     // let the buffer drain
        reg_read(R_SIZE0, rv);
        sz = int'(rv);
        reg_read(R_SIZE1, rv);
        sz = sz + (int'(rv) << 8);
        reg_read(R_SIZE2, rv);
        sz = sz + (int'(rv) << 16);
        chk0.check_eq("byte size", sz, chk0.byte_count());
    endtask

    initial begin
        int n;
        seed     = 32'hf7bc_bf10;
        bus      = '{addr: 16'h0000, wdata: 8'h00, rd: 1'b0, wr: 1'b0};
        in_write = 1'b0;
        in_data  = 32'h0;
        usb_read = 1'b0;
        n = 0;
        while (RST !== 1'b0) begin
            @(negedge BUS_CLK);
            n++;
            if (n > 20)
                abort_run("reset never released");
        end

        // reset values
        reg_read(R_CTRL, rv);
        chk0.check_eq("version", int'(rv), 2);
        reg_read(R_AF, rv);
        chk0.check_eq("af default", int'(rv), 255 * AF_PCT / 100);
        reg_read(R_AE, rv);
        chk0.check_eq("ae default", int'(rv), 255 * AE_PCT / 100);
        reg_read(R_ERR, rv);
        chk0.check_eq("err count", int'(rv), 0);
        chk0.check_eq("in_ready", int'(in_ready), 1);
        chk0.check_eq("flags", int'({fifo_not_empty, fifo_full, near_full, read_error}), 0);
        chk0.check_eq("sram strobes idle", int'({sram_we_n, sram_oe_n}), 3);

        // random traffic
        for (int i = 0; i < 24; i++) begin
            seed = xorshift32(seed);
            write_word(seed);
            repeat (int'(seed[9:8])) @(posedge BUS_CLK);
        end
        drain_all();

        // fill the ring and the buffer
        n = 0;
        while (!fifo_full) begin
            seed = xorshift32(seed);
            write_word(seed);
            @(negedge BUS_CLK);
            n++;
            if (n > 4 * DEPTH)
                abort_run("fifo_full never rose");
        end
        @(negedge BUS_CLK);
        while (in_ready) begin
            seed = xorshift32(seed);
            write_word(seed);
            repeat (3) @(negedge BUS_CLK);
            n++;
            if (n > 4 * DEPTH)
                abort_run("buffer never filled");
        end
        // ring keeps DEPTH-1 halves, one word is held, the buffer is full
        chk0.check_eq("fill bytes", chk0.byte_count(), 2 * (DEPTH + 2 * BUF_DEPTH));
        drain_all();

        // latched byte size
        for (int i = 0; i < 10; i++) begin
            seed = xorshift32(seed);
            write_word(seed);
        end
        check_size();
        for (int i = 0; i < 6; i++)
            read_byte(0);
        check_size();
        drain_all();

        // reads on an empty fifo
        for (int i = 0; i < 260; i++) begin
            @(posedge BUS_CLK);
            usb_read <= 1'b1;
            @(posedge BUS_CLK);
            usb_read <= 1'b0;
        end
        reg_read(R_ERR, rv);
        chk0.check_eq("err saturated", int'(rv), 255);
        reg_write(R_CTRL, 8'h01);
        reg_read(R_ERR, rv);
        chk0.check_eq("err after soft reset", int'(rv), 0);

        // near_full sets at 32 words and clears at 16 words
        reg_write(R_AF, 8'd127);
        reg_write(R_AE, 8'd63);
        for (int r = 0; r < 5; r++) begin
            for (int i = 0; i < 4; i++) begin
                seed = xorshift32(seed);
                write_word(seed);
            end
            repeat (20) @(posedge BUS_CLK);
            chk0.check_near_full();
        end
        n = 0;
        while (chk0.byte_count() > 0) begin
            for (int i = 0; i < 4; i++)
                read_byte(0);
            repeat (4) @(posedge BUS_CLK);
            chk0.check_near_full();
            n++;
            if (n > 100)
                abort_run("near_full drain did not finish");
        end

        repeat (5) @(posedge BUS_CLK);
        chk0.report();
        if (chk0.errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb_sram_model.sv
// ----------------------------------------------------------------------
// behavioral asynchronous 16-bit sram with tristate data bus
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_sram_model #(
    parameter int AW = 20
) (
    input  logic          BUS_CLK,
    input  logic [AW-1:0] addr,
    inout  wire  [15:0]   io,
    input  logic          we_n,
    input  logic          oe_n
);

    logic [15:0] mem [0:(1<<AW)-1];

    // write strobe spans the whole cycle, data taken at its end
    always @(posedge BUS_CLK) begin
        if (!we_n)
            mem[addr] <= io;
    end

    assign io = (!oe_n && we_n) ? mem[addr] : 16'hzzzz;   // async read

endmodule

//--- word_buffer_fifo.sv
// ----------------------------------------------------------------------
// word buffer fifo
// small register-array fifo with show-ahead output between the
// detector-side source and the sram writer
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module word_buffer_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             BUS_CLK,
    input  logic             RST,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge BUS_CLK) begin
        if (push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout  = mem[rd_ptr];                 // head word shows without a pop
    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    a_no_push_full: assert property (@(posedge BUS_CLK) disable iff (RST) !(push && full));
    a_no_pop_empty: assert property (@(posedge BUS_CLK) disable iff (RST) !(pop && empty));

endmodule
